//--- bench/tb_slm_ctrl.sv
// ==========================================================
// testbench for the image path
// host and display drivers, LFSR stimulus
// reference image model and checking assertions
// ==========================================================
`timescale 1ns/1ps
`include "slm_config.svh"

module tb_slm_ctrl;

    logic       clk;
    logic       rst_n;
    logic       cmd_req;
    logic [7:0] cmd_data;
    logic       line_req;
    logic [2:0] line_idx;
    logic       pix_ready;
    logic       cmd_ack;
    logic       line_ack;
    logic       pix_valid;
    logic [7:0] pix_data;
    logic       pix_last;

    // reference frames mirrored from each load
    logic [7:0] ref_img [`SLM_NUM_FRAMES][`SLM_IMG_H][`SLM_IMG_W];

    // decoder state as the host has set it
    int cur_h;
    int cur_v;
    int cur_frame;
    // context of the line being streamed
    int exp_line;
    int exp_h;
    int exp_v;
    int exp_frame;
    int col_q;

    logic [31:0] lfsr_q;
    logic        rand_ready;
    int          fail_cnt;
    int          tmo_cnt;
    int          pix_cnt;

    slm_ctrl_top dut_i (
        .clock_50  (clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd_data  (cmd_data),
        .line_req  (line_req),
        .line_idx  (line_idx),
        .pix_ready (pix_ready),
        .cmd_ack   (cmd_ack),
        .line_ack  (line_ack),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_last  (pix_last)
    );

    always #4 clk = ~clk;

    // ======================================================
    // stimulus helpers
    // ======================================================
    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    task automatic next_rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            b = {b[6:0], lfsr_q[0]};
        end
    endtask

    // source pixel is output position minus offset and black outside
    function automatic logic [7:0] ref_pixel(input int f, input int y, input int x,
                                             input int h, input int v);
        int sx;
        int sy;
        sx = x - h;
        sy = y - v;
        if (sx < 0 || sx >= `SLM_IMG_W || sy < 0 || sy >= `SLM_IMG_H) begin
            return 8'h00;
        end
        return ref_img[f][sy][sx];
    endfunction

    // one four-phase byte transfer on the host port
    task automatic send_byte(input logic [7:0] b);
        int n;
        @(posedge clk);
        cmd_data <= b;
        cmd_req  <= 1'b1;
        n = 0;
        while (!cmd_ack && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!cmd_ack) begin
            tmo_cnt++;
            $display("timeout at %0t: cmd_ack never rose for byte %02h", $time, b);
        end
        cmd_req <= 1'b0;
        n = 0;
        while (cmd_ack && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (cmd_ack) begin
            tmo_cnt++;
            $display("timeout at %0t: cmd_ack stayed high after cmd_req fell", $time);
        end
    endtask

    task automatic set_offsets(input int h, input int v);
        send_byte(`SLM_OP_SET_H);
        send_byte(8'(h));
        send_byte(`SLM_OP_SET_V);
        send_byte(8'(v));
        cur_h = h;
        cur_v = v;
    endtask

    task automatic select_frame(input int f);
        send_byte(`SLM_OP_SEL_FRAME);
        send_byte(8'(f));
        cur_frame = f;
    endtask

    // full image download mirrored into the reference
    task automatic load_image(input int f);
        logic [7:0] b;
        send_byte(`SLM_OP_LOAD);
        send_byte(8'(f));
        for (int i = 0; i < `SLM_IMG_W * `SLM_IMG_H; i++) begin
            next_rand_byte(b);
            ref_img[f][i / `SLM_IMG_W][i % `SLM_IMG_W] = b;
            send_byte(b);
        end
    endtask

    // one four-phase line request on the display port
    task automatic request_line(input int y);
        int n;
        @(posedge clk);
        line_idx  <= 3'(y);
        line_req  <= 1'b1;
        exp_line  <= y;
        exp_h     <= cur_h;
        exp_v     <= cur_v;
        exp_frame <= cur_frame;
        n = 0;
        while (!line_ack && n < 400) begin
            @(posedge clk);
            n++;
        end
        if (!line_ack) begin
            tmo_cnt++;
            $display("timeout at %0t: no line_ack for line %0d", $time, y);
        end
        line_req <= 1'b0;
        n = 0;
        while (line_ack && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (line_ack) begin
            tmo_cnt++;
            $display("timeout at %0t: line_ack stayed high after line_req fell", $time);
        end
    endtask

    task automatic stream_all_lines();
        for (int y = 0; y < `SLM_IMG_H; y++) begin
            request_line(y);
        end
    endtask

    // ======================================================
    // display side sink and column tracking
    // ======================================================
    always @(posedge clk) begin
        if (rand_ready) begin
            lfsr_q = lfsr_next(lfsr_q);
            pix_ready <= lfsr_q[0];
        end else begin
            pix_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            col_q <= 0;
        end else if (pix_valid && pix_ready) begin
            col_q   <= (col_q == `SLM_IMG_W - 1) ? 0 : col_q + 1;
            pix_cnt <= pix_cnt + 1;
        end
    end

    // ======================================================
    // checks
    // ======================================================
    reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !cmd_ack && !line_ack && !pix_valid && !pix_last)
        else begin
            fail_cnt++;
            $display("[FAIL] %0t: outputs not idle after reset", $time);
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_req) |=> $rose(cmd_ack))
        else begin
            fail_cnt++;
            $display("[FAIL] %0t: cmd_ack did not rise one cycle after cmd_req", $time);
        end

    pixel_match: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid && pix_ready |->
            pix_data == ref_pixel(exp_frame, exp_line, col_q, exp_h, exp_v) &&
            pix_last == (col_q == `SLM_IMG_W - 1))
        else begin
            fail_cnt++;
            $display("[FAIL] %0t: line %0d col %0d got %02h last %0b, expected %02h",
                     $time, exp_line, col_q, pix_data, pix_last,
                     ref_pixel(exp_frame, exp_line, col_q, exp_h, exp_v));
        end

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_data) && $stable(pix_last))
        else begin
            fail_cnt++;
            $display("[FAIL] %0t: pixel outputs changed while stalled", $time);
        end

    ack_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid && pix_ready && pix_last |=> line_ack)
        else begin
            fail_cnt++;
            $display("[FAIL] %0t: line_ack missing after the last pixel", $time);
        end

    ack_only_at_end: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(line_ack) |-> $past(pix_valid && pix_ready && pix_last) && col_q == 0)
        else begin
            fail_cnt++;
            $display("[FAIL] %0t: line_ack rose without a full line", $time);
        end

    ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        line_ack && !line_req |=> !line_ack)
        else begin
            fail_cnt++;
            $display("[FAIL] %0t: line_ack held after line_req fell", $time);
        end

    // ======================================================
    // test sequence
    // ======================================================
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        cmd_req    = 1'b0;
        cmd_data   = 8'h00;
        line_req   = 1'b0;
        line_idx   = 3'd0;
        pix_ready  = 1'b1;
        rand_ready = 1'b0;
        lfsr_q     = 32'h9ae6;
        fail_cnt   = 0;
        tmo_cnt    = 0;
        pix_cnt    = 0;
        cur_h      = 0;
        cur_v      = 0;
        cur_frame  = 0;
        exp_line   = 0;
        exp_h      = 0;
        exp_v      = 0;
        exp_frame  = 0;
        for (int f = 0; f < `SLM_NUM_FRAMES; f++) begin
            for (int y = 0; y < `SLM_IMG_H; y++) begin
                for (int x = 0; x < `SLM_IMG_W; x++) begin
                    ref_img[f][y][x] = 8'h00;
                end
            end
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // empty store streams black
        request_line(3);

        // frame 0 without shift
        load_image(0);
        stream_all_lines();

        // shifted right 3 and up 2
        set_offsets(3, -2);
        stream_all_lines();

        // two more frames and a switch between them
        set_offsets(0, 0);
        load_image(1);
        load_image(2);
        select_frame(1);
        stream_all_lines();
        select_frame(2);
        stream_all_lines();
        // unknown opcode is a no-op
        send_byte(8'h5a);
        stream_all_lines();

        // random back-pressure on the pixel stream
        set_offsets(-2, 1);
        rand_ready <= 1'b1;
        stream_all_lines();
        rand_ready <= 1'b0;

        repeat (4) @(posedge clk);
        $display("errors: %0d failed checks, %0d timeouts (%0d pixels checked)",
                 fail_cnt, tmo_cnt, pix_cnt);
        if (fail_cnt == 0 && tmo_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- hw/cmd_decoder.sv
// ==========================================================
// host byte port with four-phase req/ack
// opcode parser, offset and frame registers
// ==========================================================
`timescale 1ns/1ps
`include "slm_config.svh"

module cmd_decoder (
    input  logic                clock_50,
    input  logic                rst_n,
    input  logic                cmd_req,
    input  slm_pkg::pixel_t     cmd_data,
    input  logic                load_done,
    output logic                cmd_ack,
    output slm_pkg::offset_t    h_offset,
    output slm_pkg::offset_t    v_offset,
    output slm_pkg::frame_t     disp_frame,
    output logic                wr_start,
    output slm_pkg::frame_t     load_frame,
    output logic                pix_wr,
    output slm_pkg::pixel_t     pix_byte
);

    slm_pkg::dec_state_t state;
    slm_pkg::pixel_t     op_q;
    logic                take;

    // new byte on the port and not yet acked
    assign take = cmd_req && !cmd_ack;

    // ack follows req by one cycle in both directions
    always_ff @(posedge clock_50) begin
        if (!rst_n) begin
            cmd_ack <= 1'b0;
        end else begin
            cmd_ack <= cmd_req;
        end
    end

    // load start goes out with the frame argument byte
    assign wr_start   = take && (state == slm_pkg::ARG) && (op_q == `SLM_OP_LOAD);
    assign load_frame = cmd_data[`SLM_FRAME_W-1:0];

    // image bytes pass straight to the writer
    assign pix_wr   = take && (state == slm_pkg::LOAD);
    assign pix_byte = cmd_data;

    // ======================================================
    // parser FSM
    // ======================================================
    always_ff @(posedge clock_50) begin
        if (!rst_n) begin
            state      <= slm_pkg::IDLE;
            h_offset   <= '0;
            v_offset   <= '0;
            disp_frame <= '0;
        end else begin
            case (state)
                slm_pkg::IDLE: begin
                    if (take) begin
                        op_q <= cmd_data;
                        // unknown opcode is dropped here
                        if (cmd_data == `SLM_OP_SET_H || cmd_data == `SLM_OP_SET_V ||
                            cmd_data == `SLM_OP_SEL_FRAME || cmd_data == `SLM_OP_LOAD) begin
                            state <= slm_pkg::ARG;
                        end else begin
                            state <= slm_pkg::WAIT_LOW;
                        end
                    end
                end
                slm_pkg::ARG: begin
                    if (take) begin
                        state <= slm_pkg::WAIT_LOW;
                        case (op_q)
                            `SLM_OP_SET_H:     h_offset <= slm_pkg::offset_t'(cmd_data);
                            `SLM_OP_SET_V:     v_offset <= slm_pkg::offset_t'(cmd_data);
                            `SLM_OP_SEL_FRAME: disp_frame <= cmd_data[`SLM_FRAME_W-1:0];
                            `SLM_OP_LOAD:      state <= slm_pkg::LOAD;
                            default:           state <= slm_pkg::WAIT_LOW;
                        endcase
                    end
                end
                slm_pkg::LOAD: begin
                    // writer flags the last byte in its take cycle
                    if (load_done) begin
                        state <= slm_pkg::WAIT_LOW;
                    end
                end
                default: begin
                    // finish the last handshake of a command
                    if (!cmd_req) begin
                        state <= slm_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    // ack only ever answers a live request
    ack_needs_req: assert property (@(posedge clock_50) disable iff (!rst_n)
        $rose(cmd_ack) |-> cmd_req);

endmodule

//--- hw/frame_store.sv
// ==========================================================
// on-chip pixel memory for all frames
// one write port, one registered read port
// ==========================================================
`timescale 1ns/1ps
`include "slm_config.svh"

module frame_store (
    input  logic                 clock_50,
    input  logic                 rst_n,
    input  logic                 we,
    input  slm_pkg::store_addr_t waddr,
    input  slm_pkg::pixel_t      wdata,
    input  slm_pkg::store_addr_t raddr,
    output slm_pkg::pixel_t      rdata
);

    localparam int DEPTH = `SLM_NUM_FRAMES * `SLM_IMG_W * `SLM_IMG_H;

    slm_pkg::pixel_t mem [DEPTH];

    // unloaded frames read back as black
    always_ff @(posedge clock_50) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (we) begin
                mem[waddr] <= wdata;
            end
            // one cycle read latency
            rdata <= mem[raddr];
        end
    end

endmodule

//--- hw/image_writer.sv
// ==========================================================
// download sequencer into the frame store
// ==========================================================
`timescale 1ns/1ps
`include "slm_config.svh"

module image_writer (
    input  logic                 clock_50,
    input  logic                 rst_n,
    input  logic                 wr_start,
    input  slm_pkg::frame_t      load_frame,
    input  logic                 pix_wr,
    input  slm_pkg::pixel_t      pix_byte,
    output logic                 load_done,
    output logic                 we,
    output slm_pkg::store_addr_t waddr,
    output slm_pkg::pixel_t      wdata
);

    logic            active;
    slm_pkg::frame_t frame_q;
    slm_pkg::line_t  line_q;
    slm_pkg::col_t   col_q;
    logic            col_end;
    logic            line_end;

    assign col_end  = (col_q == slm_pkg::col_t'(`SLM_IMG_W - 1));
    assign line_end = (line_q == slm_pkg::line_t'(`SLM_IMG_H - 1));

    // write in the same cycle as the byte
    assign we        = pix_wr && active;
    assign waddr     = {frame_q, line_q, col_q};
    assign wdata     = pix_byte;
    assign load_done = we && col_end && line_end;

    always_ff @(posedge clock_50) begin
        if (!rst_n) begin
            active <= 1'b0;
            line_q <= '0;
            col_q  <= '0;
        end else if (wr_start) begin
            // new image, restart at the top left
            active  <= 1'b1;
            frame_q <= load_frame;
            line_q  <= '0;
            col_q   <= '0;
        end else if (we) begin
            col_q <= col_q + 1'b1;
            if (col_end) begin
                col_q  <= '0;
                line_q <= line_q + 1'b1;
            end
            if (load_done) begin
                active <= 1'b0;
            end
        end
    end

    // decoder only sends bytes inside a load block
    wr_in_load: assert property (@(posedge clock_50) disable iff (!rst_n)
        pix_wr |-> active);

endmodule

//--- hw/line_loader.sv
// ==========================================================
// display line request port and shifted line streamer
// offset address math, zero fill, back-pressured output
// ==========================================================
`timescale 1ns/1ps
`include "slm_config.svh"

module line_loader (
    input  logic                 clock_50,
    input  logic                 rst_n,
    input  logic                 line_req,
    input  slm_pkg::line_t       line_idx,
    input  slm_pkg::offset_t     h_offset,
    input  slm_pkg::offset_t     v_offset,
    input  slm_pkg::frame_t      disp_frame,
    input  slm_pkg::pixel_t      rdata,
    input  logic                 pix_ready,
    output logic                 line_ack,
    output slm_pkg::store_addr_t raddr,
    output logic                 pix_valid,
    output slm_pkg::pixel_t      pix_data,
    output logic                 pix_last
);

    // line context captured at request
    slm_pkg::line_t   line_q;
    slm_pkg::offset_t h_q;
    slm_pkg::offset_t v_q;
    slm_pkg::frame_t  frame_q;

    // issue stage
    logic             run_q;
    slm_pkg::col_t    cnt_q;
    logic signed [8:0] src_x;
    logic signed [8:0] src_y;
    logic             in_range;
    slm_pkg::store_addr_t cur_addr;

    // read in flight beside the memory register
    logic             rd_vld;
    logic             rd_inr;
    logic             rd_last;
    slm_pkg::store_addr_t rd_addr_q;

    logic             b_load;
    logic             adv;
    logic             issue;
    logic             start;

    // ======================================================
    // source position
    // ======================================================
    // source is output minus offset in 9 signed bits
    assign src_x = $signed({6'b0, cnt_q}) - $signed({h_q[7], h_q});
    assign src_y = $signed({6'b0, line_q}) - $signed({v_q[7], v_q});

    assign in_range = (src_x >= 0) && (src_x < `SLM_IMG_W) &&
                      (src_y >= 0) && (src_y < `SLM_IMG_H);

    assign cur_addr = {frame_q, src_y[`SLM_LINE_W-1:0], src_x[`SLM_COL_W-1:0]};

    // output reg free or draining
    assign b_load = !pix_valid || pix_ready;
    // read stage may move on
    assign adv    = !rd_vld || b_load;
    assign issue  = run_q && adv;

    // stalled read stage re-reads the same word so rdata holds
    assign raddr = adv ? cur_addr : rd_addr_q;

    assign start = line_req && !line_ack && !run_q && !rd_vld && !pix_valid;

    always_ff @(posedge clock_50) begin
        rd_addr_q <= raddr;
        if (start) begin
            line_q  <= line_idx;
            h_q     <= h_offset;
            v_q     <= v_offset;
            frame_q <= disp_frame;
        end
    end

    // ======================================================
    // issue, read and output stages
    // ======================================================
    always_ff @(posedge clock_50) begin
        if (!rst_n) begin
            run_q     <= 1'b0;
            cnt_q     <= '0;
            rd_vld    <= 1'b0;
            rd_inr    <= 1'b0;
            rd_last   <= 1'b0;
            pix_valid <= 1'b0;
            pix_last  <= 1'b0;
        end else begin
            if (start) begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end else if (issue) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == slm_pkg::col_t'(`SLM_IMG_W - 1)) begin
                    run_q <= 1'b0;
                end
            end
            // in-range flag rides with the read
            if (adv) begin
                rd_vld  <= issue;
                rd_inr  <= in_range;
                rd_last <= (cnt_q == slm_pkg::col_t'(`SLM_IMG_W - 1));
            end
            if (b_load) begin
                pix_valid <= rd_vld;
                pix_last  <= rd_vld && rd_last;
                if (rd_vld) begin
                    pix_data <= rd_inr ? rdata : '0;
                end
            end
        end
    end

    // ack one cycle after the last pixel is taken
    always_ff @(posedge clock_50) begin
        if (!rst_n) begin
            line_ack <= 1'b0;
        end else if (pix_valid && pix_ready && pix_last) begin
            line_ack <= 1'b1;
        end else if (!line_req) begin
            line_ack <= 1'b0;
        end
    end

    // next pixel waiting in the read stage must not move while stalled
    hold_on_stall: assert property (@(posedge clock_50) disable iff (!rst_n)
        pix_valid && !pix_ready && rd_vld |=> $stable(rdata));

endmodule

//--- hw/slm_config.svh
// ==========================================================
// image geometry, frame count, command opcodes and widths
// ==========================================================
`ifndef SLM_CONFIG_SVH
`define SLM_CONFIG_SVH

// image geometry in pixels
`define SLM_IMG_W      8
`define SLM_IMG_H      8
`define SLM_NUM_FRAMES 4

// field widths
`define SLM_PIX_W      8
`define SLM_OFS_W      8
`define SLM_FRAME_W    2
`define SLM_LINE_W     3
`define SLM_COL_W      3
`define SLM_ADDR_W     8

// host command opcodes, one byte each
`define SLM_OP_SET_H     8'h01
`define SLM_OP_SET_V     8'h02
`define SLM_OP_SEL_FRAME 8'h03
`define SLM_OP_LOAD      8'h04

`endif

//--- hw/slm_ctrl_top.sv
// ==========================================================
// image path top: decoder, writer, store, line loader
// ==========================================================
`timescale 1ns/1ps
`include "slm_config.svh"

module slm_ctrl_top (
    input  logic             clock_50,
    input  logic             rst_n,
    input  logic             cmd_req,
    input  slm_pkg::pixel_t  cmd_data,
    input  logic             line_req,
    input  slm_pkg::line_t   line_idx,
    input  logic             pix_ready,
    output logic             cmd_ack,
    output logic             line_ack,
    output logic             pix_valid,
    output slm_pkg::pixel_t  pix_data,
    output logic             pix_last
);

    // decoder outputs
    slm_pkg::offset_t     h_offset;
    slm_pkg::offset_t     v_offset;
    slm_pkg::frame_t      disp_frame;
    logic                 wr_start;
    slm_pkg::frame_t      load_frame;
    logic                 pix_wr;
    slm_pkg::pixel_t      pix_byte;

    // store ports
    logic                 load_done;
    logic                 we;
    slm_pkg::store_addr_t waddr;
    slm_pkg::pixel_t      wdata;
    slm_pkg::store_addr_t raddr;
    slm_pkg::pixel_t      rdata;

    cmd_decoder dec_i (
        .clock_50   (clock_50),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd_data   (cmd_data),
        .load_done  (load_done),
        .cmd_ack    (cmd_ack),
        .h_offset   (h_offset),
        .v_offset   (v_offset),
        .disp_frame (disp_frame),
        .wr_start   (wr_start),
        .load_frame (load_frame),
        .pix_wr     (pix_wr),
        .pix_byte   (pix_byte)
    );

    image_writer wr_i (
        .clock_50   (clock_50),
        .rst_n      (rst_n),
        .wr_start   (wr_start),
        .load_frame (load_frame),
        .pix_wr     (pix_wr),
        .pix_byte   (pix_byte),
        .load_done  (load_done),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata)
    );

    frame_store store_i (
        .clock_50 (clock_50),
        .rst_n    (rst_n),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata),
        .raddr    (raddr),
        .rdata    (rdata)
    );

    line_loader ld_i (
        .clock_50   (clock_50),
        .rst_n      (rst_n),
        .line_req   (line_req),
        .line_idx   (line_idx),
        .h_offset   (h_offset),
        .v_offset   (v_offset),
        .disp_frame (disp_frame),
        .rdata      (rdata),
        .pix_ready  (pix_ready),
        .line_ack   (line_ack),
        .raddr      (raddr),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .pix_last   (pix_last)
    );

endmodule

//--- hw/slm_pkg.sv
// ==========================================================
// shared types of the image path
// pixel, offset, index and address vectors, decoder states
// ==========================================================
`include "slm_config.svh"

package slm_pkg;

    // one pixel, also one host command byte
    typedef logic [`SLM_PIX_W-1:0] pixel_t;

    // signed shift, plus moves right or down
    typedef logic signed [`SLM_OFS_W-1:0] offset_t;

    // indices into the frame store
    typedef logic [`SLM_FRAME_W-1:0] frame_t;
    typedef logic [`SLM_LINE_W-1:0]  line_t;
    typedef logic [`SLM_COL_W-1:0]   col_t;

    // store address is {frame, line, column}
    typedef logic [`SLM_ADDR_W-1:0] store_addr_t;

    // command parser states
    typedef enum logic [1:0] {
        IDLE,
        ARG,
        LOAD,
        WAIT_LOW
    } dec_state_t;

endpackage

//--- src.f
+incdir+hw
hw/slm_pkg.sv
hw/cmd_decoder.sv
hw/image_writer.sv
hw/frame_store.sv
hw/line_loader.sv
hw/slm_ctrl_top.sv
bench/tb_slm_ctrl.sv
